/* rtl/regDemo_consts.svh */
/*
 * Sizes, seed values and default rates of the register-file demonstrator.
 * Include wherever one of these constants is needed.
 */

`ifndef REGDEMO_CONSTS_SVH
`define REGDEMO_CONSTS_SVH

// Storage geometry
`define REG_COUNT 32
`define WORD_WIDTH 32
`define ADDR_WIDTH 5

// Width of the LED output
`define LED_WIDTH 10

// First word written, counts down over the lower half
`define LOWER_SEED 32'hFFFF000F

// Word written at the start of the upper half, counts up from there
`define UPPER_SEED 32'h0000FFF0

// First address of the upper half
`define HALF_BASE 5'd16

// Shown on the LEDs while the file is being filled
`define WRITE_STATUS_LEDS 10'h200

// Slow step every 2^23 clocks, a few Hz from a 50 MHz clock
`define SLOW_DIV_BITS 23

`endif

/* rtl/regDemoPkg.sv */
/*
 * Shared types for the register-file demonstrator.
 * Sizes come from the constants header; referenced by scoped name.
 */

`default_nettype none

`include "regDemo_consts.svh"

package regDemoPkg;

	// One stored word of the register file
	typedef logic [`WORD_WIDTH-1:0] regWord;

	// Register address, wide enough for every entry
	typedef logic [`ADDR_WIDTH-1:0] regAddr;

	// Pattern shown on the LED output
	typedef logic [`LED_WIDTH-1:0] ledWord;

	// Controller phases
	// Encoding 0 is not a legal state
	typedef enum logic [2:0] {
		writeLower = 3'b001,
		writeUpper = 3'b010,
		readLower  = 3'b011,
		readUpper  = 3'b100
	} demoState;

endpackage

`default_nettype wire

/* rtl/registerFile.sv */
/*
 * Register storage with one synchronous write port and one
 * combinational read port sharing a single address.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module registerFile (
	input wire clk,
	input wire writeEn,
	input wire regDemoPkg::regAddr addr,
	input wire regDemoPkg::regWord writeData,
	output regDemoPkg::regWord readData
);

	// Plain storage, contents are undefined until written
	regDemoPkg::regWord mem [`REG_COUNT];

	// Write port
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[addr] <= writeData;
		end
	end

	// Read port returns the addressed word in the same cycle
	assign readData = mem[addr];

endmodule

`default_nettype wire

/* rtl/stepTimer.sv */
/*
 * Step pulse generator used as a clock enable for the controller.
 * Pulses every clock, or once per counter wrap when slowDown is high.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module stepTimer #(
	parameter int DIV_BITS = `SLOW_DIV_BITS
) (
	input wire clk,
	input wire rst,
	input wire slowDown,
	output logic step
);

	logic [DIV_BITS-1:0] count;
	logic wrap;

	// Free-running divider
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Last count before rolling over to zero
	assign wrap = &count;

	// Full rate or one pulse per 2^DIV_BITS clocks
	// No pulse while reset is held
	assign step = ~rst & (slowDown ? wrap : 1'b1);

endmodule

`default_nettype wire

/* rtl/patternGenerator.sv */
/*
 * Data register for the fill pattern.
 * Loads either seed or steps the word by one under sequencer command.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module patternGenerator (
	input wire clk,
	input wire rst,
	input wire loadLower,
	input wire loadUpper,
	input wire countDown,
	input wire countUp,
	output regDemoPkg::regWord writeData
);

	localparam regDemoPkg::regWord lowerSeed = `LOWER_SEED;
	localparam regDemoPkg::regWord upperSeed = `UPPER_SEED;

	regDemoPkg::regWord data;

	// Only one command is issued per step, loads win if they ever overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			data <= lowerSeed;
		end else if (loadLower) begin
			data <= lowerSeed;
		end else if (loadUpper) begin
			data <= upperSeed;
		end else if (countDown) begin
			data <= data - 1'b1;
		end else if (countUp) begin
			data <= data + 1'b1;
		end
	end

	assign writeData = data;

endmodule

`default_nettype wire

/* rtl/demoSequencer.sv */
/*
 * Controller for the register-file demonstrator.
 * Fills the file in two counting halves, then scans it onto the LEDs.
 * All actions are qualified by the step pulse from the timer.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module demoSequencer (
	input wire clk,
	input wire rst,
	input wire step,
	input wire lowerSel,
	input wire regDemoPkg::regWord readData,
	output regDemoPkg::regAddr addr,
	output logic writeEn,
	output logic loadLower,
	output logic loadUpper,
	output logic countDown,
	output logic countUp,
	output regDemoPkg::ledWord leds
);

	// Last address of each half
	localparam regDemoPkg::regAddr lastLowerAddr = `HALF_BASE - 5'd1;
	localparam regDemoPkg::regAddr lastUpperAddr = regDemoPkg::regAddr'(`REG_COUNT - 1);

	regDemoPkg::demoState state;
	regDemoPkg::ledWord readLeds;

	// Low byte of the word being read, upper LEDs dark
	assign readLeds = {2'b00, readData[7:0]};

	// Write and pattern commands, one cycle wide on step
	always_comb begin
		writeEn = 1'b0;
		loadLower = 1'b0;
		loadUpper = 1'b0;
		countDown = 1'b0;
		countUp = 1'b0;
		if (step) begin
			case (state)
				regDemoPkg::writeLower: begin
					writeEn = 1'b1;
					// Switch the pattern over for word 16
					if (addr == lastLowerAddr) begin
						loadUpper = 1'b1;
					end else begin
						countDown = 1'b1;
					end
				end
				regDemoPkg::writeUpper: begin
					writeEn = 1'b1;
					// Rearm the lower seed once the fill is done
					if (addr == lastUpperAddr) begin
						loadLower = 1'b1;
					end else begin
						countUp = 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// State, address counter and LED register
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= regDemoPkg::writeLower;
			addr <= '0;
			leds <= '0;
		end else if (step) begin
			case (state)
				regDemoPkg::writeLower: begin
					leds <= `WRITE_STATUS_LEDS;
					addr <= addr + 1'b1;
					if (addr == lastLowerAddr) begin
						state <= regDemoPkg::writeUpper;
					end
				end
				regDemoPkg::writeUpper: begin
					leds <= `WRITE_STATUS_LEDS;
					if (addr != lastUpperAddr) begin
						addr <= addr + 1'b1;
					end else if (lowerSel) begin
						state <= regDemoPkg::readLower;
						addr <= '0;
					end else begin
						state <= regDemoPkg::readUpper;
						addr <= `HALF_BASE;
					end
				end
				regDemoPkg::readLower: begin
					leds <= readLeds;
					if (lowerSel) begin
						// Wraps back to word 0 after word 31
						addr <= addr + 1'b1;
					end else begin
						state <= regDemoPkg::readUpper;
						addr <= `HALF_BASE;
					end
				end
				regDemoPkg::readUpper: begin
					leds <= readLeds;
					if (lowerSel) begin
						state <= regDemoPkg::readLower;
						addr <= '0;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				default: begin
					// Illegal encoding, start the fill over
					state <= regDemoPkg::writeLower;
					addr <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/regFileDemo.sv */
/*
 * Top level of the register-file demonstrator.
 * Ties the step timer, controller, pattern generator and storage together.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module regFileDemo #(
	parameter int SLOW_DIV_BITS = `SLOW_DIV_BITS
) (
	input wire clk,
	input wire rst,
	input wire slowDown,
	input wire lowerSel,
	output regDemoPkg::ledWord leds
);

	logic step;
	logic writeEn;
	logic loadLower;
	logic loadUpper;
	logic countDown;
	logic countUp;
	regDemoPkg::regAddr addr;
	regDemoPkg::regWord writeData;
	regDemoPkg::regWord readData;

	// Clock enable for the controller
	stepTimer #(
		.DIV_BITS(SLOW_DIV_BITS)
	) stepTimer_inst (
		.clk(clk),
		.rst(rst),
		.slowDown(slowDown),
		.step(step)
	);

	demoSequencer demoSequencer_inst (
		.clk(clk),
		.rst(rst),
		.step(step),
		.lowerSel(lowerSel),
		.readData(readData),
		.addr(addr),
		.writeEn(writeEn),
		.loadLower(loadLower),
		.loadUpper(loadUpper),
		.countDown(countDown),
		.countUp(countUp),
		.leds(leds)
	);

	patternGenerator patternGenerator_inst (
		.clk(clk),
		.rst(rst),
		.loadLower(loadLower),
		.loadUpper(loadUpper),
		.countDown(countDown),
		.countUp(countUp),
		.writeData(writeData)
	);

	// One address serves both the write and the read port
	registerFile registerFile_inst (
		.clk(clk),
		.writeEn(writeEn),
		.addr(addr),
		.writeData(writeData),
		.readData(readData)
	);

endmodule

`default_nettype wire

/* verification/regFileDemoTb.sv */
/*
 * Directed testbench for the register-file demonstrator.
 * Checks reset, the fill phase, the LED scan of both halves and the slow step rate.
 */

`timescale 1ns/1ps
`default_nettype none

`include "regDemo_consts.svh"

module regFileDemoTb;

	localparam int slowDivBits = 3;
	localparam int slowPeriod = 1 << slowDivBits;
	localparam int slowSteps = 5;

	// Cycle budget of every test added up, plus margin for the watchdog
	localparam int testCycles = 10 + 33 + 36 + 6 + 4 + slowPeriod * (slowSteps + 1);
	localparam int watchdogCycles = testCycles + 1800;

	logic clk;
	logic rst;
	logic slowDown;
	logic lowerSel;
	regDemoPkg::ledWord leds;

	// Scan position predicted from the read rules
	int scanAddr;
	bit scanLower;

	regFileDemo #(
		.SLOW_DIV_BITS(slowDivBits)
	) regFileDemo_inst (
		.clk(clk),
		.rst(rst),
		.slowDown(slowDown),
		.lowerSel(lowerSel),
		.leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// Inputs change and outputs are sampled 1 ns after the rising edge
	task automatic waitCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkLeds(input regDemoPkg::ledWord expected);
		if (leds !== expected) begin
			abortRun($sformatf("Error at %0t ns: leds expected %h, got %h",
				$time, expected, leds));
		end
	endtask

	task automatic checkState(input regDemoPkg::demoState expected);
		regDemoPkg::demoState actual;
		actual = regFileDemo_inst.demoSequencer_inst.state;
		if (actual !== expected) begin
			abortRun($sformatf("Error at %0t ns: state expected %s, got %s (%0d)",
				$time, expected.name(), actual.name(), actual));
		end
	endtask

	// Fill value of a word: lower half counts down, upper half counts up
	function automatic regDemoPkg::regWord patternWord(input int index);
		if (index < `HALF_BASE) begin
			return regDemoPkg::regWord'(`LOWER_SEED - index);
		end
		return regDemoPkg::regWord'(`UPPER_SEED + (index - `HALF_BASE));
	endfunction

	function automatic regDemoPkg::ledWord expectedLeds(input int index);
		regDemoPkg::regWord word;
		word = patternWord(index);
		return {2'b00, word[7:0]};
	endfunction

	// One read step: show the current word, then move on as lowerSel asks
	task automatic scanCycle();
		regDemoPkg::ledWord expected;
		expected = expectedLeds(scanAddr);
		if (scanLower == lowerSel) begin
			scanAddr = (scanAddr + 1) % `REG_COUNT;
		end else begin
			scanLower = lowerSel;
			scanAddr = lowerSel ? 0 : `HALF_BASE;
		end
		waitCycle();
		checkLeds(expected);
		checkState(scanLower ? regDemoPkg::readLower : regDemoPkg::readUpper);
	endtask

	task automatic resetTest();
		repeat (10) begin
			waitCycle();
			checkLeds('0);
			checkState(regDemoPkg::writeLower);
		end
		rst = 1'b0;
		// Late in the first cycle out of reset nothing has moved yet
		#5;
		checkLeds('0);
		checkState(regDemoPkg::writeLower);
	endtask

	task automatic writePhaseTest();
		for (int k = 1; k <= `REG_COUNT; k++) begin
			waitCycle();
			checkLeds(`WRITE_STATUS_LEDS);
			if (k < `HALF_BASE) begin
				checkState(regDemoPkg::writeLower);
			end else if (k < `REG_COUNT) begin
				checkState(regDemoPkg::writeUpper);
			end else begin
				checkState(regDemoPkg::readLower);
			end
		end
		scanAddr = 0;
		scanLower = 1'b1;
	endtask

	task automatic lowerScanTest();
		// Full pass over the file and a few words past the wrap
		repeat (`REG_COUNT + 4) begin
			scanCycle();
		end
	endtask

	task automatic halfSwitchTest();
		lowerSel = 1'b0;
		repeat (6) begin
			scanCycle();
		end
	endtask

	task automatic restartTest();
		lowerSel = 1'b1;
		repeat (4) begin
			scanCycle();
		end
	endtask

	task automatic slowRateTest();
		regDemoPkg::ledWord previous;
		regDemoPkg::ledWord expected;
		int waited;
		slowDown = 1'b1;
		previous = leds;
		expected = expectedLeds(scanAddr);
		scanAddr = (scanAddr + 1) % `REG_COUNT;
		waited = 0;
		// First slow step lands somewhere in the next divider period
		while (leds === previous) begin
			if (waited == slowPeriod) begin
				abortRun("leds did not change within one slow step period");
			end
			waitCycle();
			waited++;
		end
		checkLeds(expected);
		repeat (slowSteps) begin
			previous = expected;
			expected = expectedLeds(scanAddr);
			scanAddr = (scanAddr + 1) % `REG_COUNT;
			repeat (slowPeriod - 1) begin
				waitCycle();
				checkLeds(previous);
			end
			waitCycle();
			checkLeds(expected);
		end
	endtask

	initial begin
		repeat (watchdogCycles) begin
			@(posedge clk);
		end
		abortRun($sformatf("Watchdog expired after %0d cycles", watchdogCycles));
	end

	initial begin
		rst = 1'b1;
		slowDown = 1'b0;
		lowerSel = 1'b1;
		scanAddr = 0;
		scanLower = 1'b1;
		resetTest();
		writePhaseTest();
		lowerScanTest();
		halfSwitchTest();
		restartTest();
		slowRateTest();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/regDemoPkg.sv
rtl/registerFile.sv
rtl/stepTimer.sv
rtl/patternGenerator.sv
rtl/demoSequencer.sv
rtl/regFileDemo.sv
verification/regFileDemoTb.sv

/* Bender.yml */
package:
  name: reg_file_demo

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/regDemoPkg.sv
      - rtl/registerFile.sv
      - rtl/stepTimer.sv
      - rtl/patternGenerator.sv
      - rtl/demoSequencer.sv
      - rtl/regFileDemo.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/regFileDemoTb.sv
